// ==== logic/ctrlport_pkg.sv ====
`default_nettype none

package ctrlport_pkg;

  // ----------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------

  localparam int ADDR_W    = 20;
  localparam int DATA_W    = 32;
  localparam int BYTE_EN_W = DATA_W / 8;
  localparam int TIME_W    = 64;
  localparam int STATUS_W  = 2;

  // Response status codes, encoded as on the control-port bus
  typedef enum logic [STATUS_W-1:0] {
    STS_OKAY    = 2'd0,
    STS_CMDERR  = 2'd1,
    STS_TSERR   = 2'd2,
    STS_WARNING = 2'd3
  } ctrl_status_t;

  // ----------------------------------------------------------
  // Address map
  // ----------------------------------------------------------

  // Scratch registers sit at consecutive word addresses from the base
  localparam int NUM_SCRATCH   = 4;
  localparam int SCRATCH_IDX_W = $clog2(NUM_SCRATCH);
  localparam logic [ADDR_W-1:0] REG_BANK_BASE = 'h000;

  // The timekeeper occupies two words, low half first
  localparam logic [ADDR_W-1:0] TIMEKEEPER_BASE = 'h100;
  localparam logic [ADDR_W-1:0] TIME_LO         = TIMEKEEPER_BASE + 'h0;
  localparam logic [ADDR_W-1:0] TIME_HI         = TIMEKEEPER_BASE + 'h4;

  // Slaves behind the splitter and their slots in the bus array
  localparam int NUM_CTRL_SLAVES = 2;
  localparam int SLV_REG_BANK    = 0;
  localparam int SLV_TIMEKEEPER  = 1;

  // ----------------------------------------------------------
  // Response timeout
  // ----------------------------------------------------------

  // Cycles the gate waits in WAIT_ACK before it answers with a command error
  localparam int RESP_TIMEOUT = 32;
  localparam int TIMEOUT_W    = $clog2(RESP_TIMEOUT);

endpackage

`default_nettype wire

// ==== logic/ctrlport_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlport_if;
  import ctrlport_pkg::*;

  // Request half, driven by the master
  logic                 req_wr;
  logic                 req_rd;
  logic [ADDR_W-1:0]    req_addr;
  logic [DATA_W-1:0]    req_data;
  logic [BYTE_EN_W-1:0] req_byte_en;
  logic                 req_has_time;
  logic [TIME_W-1:0]    req_time;

  // Response half, driven by the slave
  logic                 resp_ack;
  ctrl_status_t         resp_status;
  logic [DATA_W-1:0]    resp_data;

  modport master (
    output req_wr, req_rd, req_addr, req_data, req_byte_en,
    output req_has_time, req_time,
    input  resp_ack, resp_status, resp_data
  );

  modport slave (
    input  req_wr, req_rd, req_addr, req_data, req_byte_en,
    input  req_has_time, req_time,
    output resp_ack, resp_status, resp_data
  );

endinterface

`default_nettype wire

// ==== logic/ctrlport_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlport_splitter #(
  parameter int NUM_SLAVES = ctrlport_pkg::NUM_CTRL_SLAVES
) (
  input wire ctrlport_clk,
  input wire ctrlport_rst,
  ctrlport_if.slave  s,
  ctrlport_if.master m [NUM_SLAVES]
);
  import ctrlport_pkg::*;

  // Responses of all slaves gathered into plain arrays
  logic [NUM_SLAVES-1:0] slv_ack;
  logic [STATUS_W-1:0]   slv_status [NUM_SLAVES];
  logic [DATA_W-1:0]     slv_data   [NUM_SLAVES];

  // ----------------------------------------------------------
  // Request fan-out
  // ----------------------------------------------------------

  // Every slave sees every request, each one decodes its own address range
  for (genvar i = 0; i < NUM_SLAVES; i++) begin : gen_fanout
    assign m[i].req_wr       = s.req_wr;
    assign m[i].req_rd       = s.req_rd;
    assign m[i].req_addr     = s.req_addr;
    assign m[i].req_data     = s.req_data;
    assign m[i].req_byte_en  = s.req_byte_en;
    assign m[i].req_has_time = s.req_has_time;
    assign m[i].req_time     = s.req_time;

    assign slv_ack[i]    = m[i].resp_ack;
    assign slv_status[i] = m[i].resp_status;
    assign slv_data[i]   = m[i].resp_data;
  end

  // ----------------------------------------------------------
  // Response merge
  // ----------------------------------------------------------

  if (NUM_SLAVES == 1) begin : gen_single
    // A lone slave needs no merging and no extra cycle
    assign s.resp_ack    = slv_ack[0];
    assign s.resp_status = ctrl_status_t'(slv_status[0]);
    assign s.resp_data   = slv_data[0];
  end else begin : gen_merge
    logic                ack_or;
    logic [STATUS_W-1:0] status_or;
    logic [DATA_W-1:0]   data_or;

    // Only the acknowledging slave contributes, so a plain OR is enough
    always_comb begin
      ack_or    = 1'b0;
      status_or = '0;
      data_or   = '0;
      for (int i = 0; i < NUM_SLAVES; i++) begin
        ack_or    = ack_or | slv_ack[i];
        status_or = status_or | (slv_status[i] & {STATUS_W{slv_ack[i]}});
        data_or   = data_or | (slv_data[i] & {DATA_W{slv_ack[i]}});
      end
    end

    // Register the merged response to break the long OR path
    always_ff @(posedge ctrlport_clk) begin
      if (ctrlport_rst) begin
        s.resp_ack <= 1'b0;
      end else begin
        s.resp_ack <= ack_or;
      end
    end

    always_ff @(posedge ctrlport_clk) begin
      s.resp_status <= ctrl_status_t'(status_or);
      s.resp_data   <= data_or;
    end
  end

  // The masked OR is only valid if the address ranges never overlap
  assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst) $onehot0(slv_ack))
    else $error("Several slaves acknowledged the same request");

endmodule

`default_nettype wire

// ==== logic/ctrlport_timed_gate.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlport_timed_gate (
  input  wire                              ctrlport_clk,
  input  wire                              ctrlport_rst,
  input  wire                              req_wr,
  input  wire                              req_rd,
  input  wire [ctrlport_pkg::ADDR_W-1:0]   req_addr,
  input  wire [ctrlport_pkg::DATA_W-1:0]   req_data,
  input  wire [ctrlport_pkg::BYTE_EN_W-1:0] req_byte_en,
  input  wire                              req_has_time,
  input  wire [ctrlport_pkg::TIME_W-1:0]   req_time,
  output logic                             resp_ack,
  output ctrlport_pkg::ctrl_status_t       resp_status,
  output logic [ctrlport_pkg::DATA_W-1:0]  resp_data,
  input  wire [ctrlport_pkg::TIME_W-1:0]   time_now,
  ctrlport_if.master                       m
);
  import ctrlport_pkg::*;

  typedef enum logic [2:0] {IDLE, WAIT_TIME, ISSUE, WAIT_ACK, RESPOND} state_t;

  state_t               state;
  logic                 req_valid;
  logic                 req_late;
  logic                 req_now;
  logic                 hold_wr;
  logic                 hold_rd;
  logic [ADDR_W-1:0]    hold_addr;
  logic [DATA_W-1:0]    hold_data;
  logic [BYTE_EN_W-1:0] hold_byte_en;
  logic                 hold_has_time;
  logic [TIME_W-1:0]    hold_time;
  logic [TIMEOUT_W-1:0] tmo_cnt;
  ctrl_status_t         resp_status_r;
  logic [DATA_W-1:0]    resp_data_r;

  assign req_valid = req_wr || req_rd;
  // A timed request in the past is refused, one due right now goes straight out
  assign req_late  = req_has_time && (req_time < time_now);
  assign req_now   = !req_has_time || (req_time == time_now);

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (req_valid) begin
            if (req_late) begin
              state <= RESPOND;
            end else if (req_now) begin
              state <= ISSUE;
            end else begin
              state <= WAIT_TIME;
            end
          end
        end
        // Greater-or-equal also catches a time that was set past the target
        WAIT_TIME: if (time_now >= hold_time) state <= ISSUE;
        ISSUE:     state <= WAIT_ACK;
        WAIT_ACK:  if (m.resp_ack || tmo_cnt == '0) state <= RESPOND;
        default:   state <= IDLE;
      endcase
    end
  end

  // Holding registers, timeout counter and response register
  always_ff @(posedge ctrlport_clk) begin
    case (state)
      IDLE: begin
        if (req_valid) begin
          hold_wr       <= req_wr;
          hold_rd       <= req_rd;
          hold_addr     <= req_addr;
          hold_data     <= req_data;
          hold_byte_en  <= req_byte_en;
          hold_has_time <= req_has_time;
          hold_time     <= req_time;
          // Preset for the reject path, overwritten later if the request goes out
          resp_status_r <= STS_TSERR;
          resp_data_r   <= '0;
        end
      end
      ISSUE: tmo_cnt <= TIMEOUT_W'(RESP_TIMEOUT - 1);
      WAIT_ACK: begin
        tmo_cnt <= tmo_cnt - 1'b1;
        if (m.resp_ack) begin
          resp_status_r <= m.resp_status;
          resp_data_r   <= m.resp_data;
        end else if (tmo_cnt == '0) begin
          resp_status_r <= STS_CMDERR;
          resp_data_r   <= '0;
        end
      end
      default: ;
    endcase
  end

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------

  // Strobes pulse for the single ISSUE cycle
  assign m.req_wr       = (state == ISSUE) && hold_wr;
  assign m.req_rd       = (state == ISSUE) && hold_rd;
  assign m.req_addr     = hold_addr;
  assign m.req_data     = hold_data;
  assign m.req_byte_en  = hold_byte_en;
  assign m.req_has_time = hold_has_time;
  assign m.req_time     = hold_time;

  assign resp_ack    = (state == RESPOND);
  assign resp_status = resp_status_r;
  assign resp_data   = resp_data_r;

  // Control port has no back-pressure, so the master must wait for its answer
  assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst)
    req_valid |-> state == IDLE)
    else $error("Request arrived while a previous one was outstanding");

  assert property (@(posedge ctrlport_clk) disable iff (ctrlport_rst) !(req_wr && req_rd))
    else $error("Read and write requested in the same cycle");

endmodule

`default_nettype wire

// ==== logic/ctrlport_timekeeper.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlport_timekeeper (
  input  wire                             ctrlport_clk,
  input  wire                             ctrlport_rst,
  ctrlport_if.slave                       s,
  output logic [ctrlport_pkg::TIME_W-1:0] time_now
);
  import ctrlport_pkg::*;

  logic [TIME_W-1:0] time_cnt;
  // High half written ahead of the committing low-half write
  logic [DATA_W-1:0] hi_stage;
  // High half captured with the last low-half read, so a 64-bit read is coherent
  logic [DATA_W-1:0] hi_latch;
  logic              hit;
  logic              sel_hi;

  // Two words, told apart by address bit 2
  assign hit    = (s.req_addr[ADDR_W-1:3] == TIMEKEEPER_BASE[ADDR_W-1:3]);
  assign sel_hi = (s.req_addr[2] == TIME_HI[2]);

  // ----------------------------------------------------------
  // Counter and word staging
  // ----------------------------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      time_cnt   <= '0;
      hi_stage   <= '0;
      hi_latch   <= '0;
      s.resp_ack <= 1'b0;
    end else begin
      s.resp_ack <= hit && (s.req_wr || s.req_rd);

      // Writing the low word commits the whole time, otherwise it counts
      if (hit && s.req_wr && !sel_hi) begin
        time_cnt <= {hi_stage, s.req_data};
      end else begin
        time_cnt <= time_cnt + 1'b1;
      end

      if (hit && s.req_wr && sel_hi) begin
        hi_stage <= s.req_data;
      end

      if (hit && s.req_rd && !sel_hi) begin
        hi_latch <= time_cnt[TIME_W-1:DATA_W];
      end
    end
  end

  // ----------------------------------------------------------
  // Read data
  // ----------------------------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (hit) begin
      if (!s.req_rd) begin
        s.resp_data <= '0;
      end else if (sel_hi) begin
        s.resp_data <= hi_latch;
      end else begin
        s.resp_data <= time_cnt[DATA_W-1:0];
      end
    end
  end

  // Every mapped word answers without error
  assign s.resp_status = STS_OKAY;

  assign time_now = time_cnt;

endmodule

`default_nettype wire

// ==== logic/ctrlport_reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlport_reg_bank (
  input wire        ctrlport_clk,
  input wire        ctrlport_rst,
  ctrlport_if.slave s
);
  import ctrlport_pkg::*;

  logic [DATA_W-1:0]        scratch [NUM_SCRATCH];
  logic                     hit;
  logic [SCRATCH_IDX_W-1:0] word_idx;

  // The bank covers NUM_SCRATCH words from its base, byte offset ignored
  assign hit      = (s.req_addr[ADDR_W-1:SCRATCH_IDX_W+2] ==
                     REG_BANK_BASE[ADDR_W-1:SCRATCH_IDX_W+2]);
  assign word_idx = s.req_addr[SCRATCH_IDX_W+1:2];

  // ----------------------------------------------------------
  // Register writes
  // ----------------------------------------------------------

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      for (int i = 0; i < NUM_SCRATCH; i++) begin
        scratch[i] <= '0;
      end
      s.resp_ack <= 1'b0;
    end else begin
      s.resp_ack <= hit && (s.req_wr || s.req_rd);
      if (hit && s.req_wr) begin
        // Each byte lane only changes when its enable is set
        for (int b = 0; b < BYTE_EN_W; b++) begin
          if (s.req_byte_en[b]) begin
            scratch[word_idx][8*b +: 8] <= s.req_data[8*b +: 8];
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Read data
  // ----------------------------------------------------------

  // Writes answer with zero data
  always_ff @(posedge ctrlport_clk) begin
    if (hit) begin
      s.resp_data <= s.req_rd ? scratch[word_idx] : '0;
    end
  end

  assign s.resp_status = STS_OKAY;

endmodule

`default_nettype wire

// ==== logic/ctrlport_timed_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrlport_timed_regs (
  input  wire                               ctrlport_clk,
  input  wire                               ctrlport_rst,
  input  wire                               req_wr,
  input  wire                               req_rd,
  input  wire [ctrlport_pkg::ADDR_W-1:0]    req_addr,
  input  wire [ctrlport_pkg::DATA_W-1:0]    req_data,
  input  wire [ctrlport_pkg::BYTE_EN_W-1:0] req_byte_en,
  input  wire                               req_has_time,
  input  wire [ctrlport_pkg::TIME_W-1:0]    req_time,
  output logic                              resp_ack,
  output ctrlport_pkg::ctrl_status_t        resp_status,
  output logic [ctrlport_pkg::DATA_W-1:0]   resp_data
);
  import ctrlport_pkg::*;

  // Current time, fed back from the timekeeper to the gate
  logic [TIME_W-1:0] time_now;

  ctrlport_if gate_bus ();
  ctrlport_if slave_bus [NUM_CTRL_SLAVES] ();

  // Timed requests wait here until their time comes up
  ctrlport_timed_gate i_gate (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (req_wr),
    .req_rd       (req_rd),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .req_byte_en  (req_byte_en),
    .req_has_time (req_has_time),
    .req_time     (req_time),
    .resp_ack     (resp_ack),
    .resp_status  (resp_status),
    .resp_data    (resp_data),
    .time_now     (time_now),
    .m            (gate_bus)
  );

  ctrlport_splitter #(
    .NUM_SLAVES (NUM_CTRL_SLAVES)
  ) i_splitter (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .s            (gate_bus),
    .m            (slave_bus)
  );

  ctrlport_reg_bank i_reg_bank (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .s            (slave_bus[SLV_REG_BANK])
  );

  ctrlport_timekeeper i_timekeeper (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .s            (slave_bus[SLV_TIMEKEEPER]),
    .time_now     (time_now)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_ctrlport_timed_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ctrlport_timed_regs;
  import ctrlport_pkg::*;

  // Timing modes of a table row
  localparam logic [1:0] TM_NONE  = 2'd0;
  localparam logic [1:0] TM_AHEAD = 2'd1;
  localparam logic [1:0] TM_LATE  = 2'd2;

  // Ways to judge the read data of a row
  localparam logic [1:0] EXP_FIXED = 2'd0;
  localparam logic [1:0] EXP_MODEL = 2'd1;
  localparam logic [1:0] EXP_MIN   = 2'd2;

  // Time loaded into the timekeeper, low half far from a carry into the high half
  localparam logic [DATA_W-1:0] T_HI = 32'h0000_0005;
  localparam logic [DATA_W-1:0] T_LO = 32'h1000_0000;
  localparam int ACK_LIMIT = RESP_TIMEOUT + 64;

  typedef struct {
    logic                 wr;
    logic [ADDR_W-1:0]    addr;
    logic [DATA_W-1:0]    data;
    logic [BYTE_EN_W-1:0] byte_en;
    logic [1:0]           tm;
    int                   t_ofs;
    ctrl_status_t         sts;
    logic [1:0]           mode;
    logic [DATA_W-1:0]    exp_data;
  } row_t;

  logic                 ctrlport_clk;
  logic                 ctrlport_rst;
  logic                 req_wr;
  logic                 req_rd;
  logic [ADDR_W-1:0]    req_addr;
  logic [DATA_W-1:0]    req_data;
  logic [BYTE_EN_W-1:0] req_byte_en;
  logic                 req_has_time;
  logic [TIME_W-1:0]    req_time;
  logic                 resp_ack;
  ctrl_status_t         resp_status;
  logic [DATA_W-1:0]    resp_data;

  row_t              rows [$];
  // Reference copy of the scratch registers
  logic [DATA_W-1:0] model [NUM_SCRATCH];
  // Low half of the last TIME_LO read, base for timed requests
  logic [DATA_W-1:0] last_lo;
  // Lowest low half a TIME_LO read may return
  logic [DATA_W-1:0] min_lo;
  int                seed = 30258;

  ctrlport_timed_regs i_dut (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (req_wr),
    .req_rd       (req_rd),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .req_byte_en  (req_byte_en),
    .req_has_time (req_has_time),
    .req_time     (req_time),
    .resp_ack     (resp_ack),
    .resp_status  (resp_status),
    .resp_data    (resp_data)
  );

  initial begin
    ctrlport_clk = 1'b0;
    forever #50 ctrlport_clk = ~ctrlport_clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic add_row(input logic wr, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] data, input logic [BYTE_EN_W-1:0] byte_en,
                         input logic [1:0] tm, input int t_ofs, input ctrl_status_t sts,
                         input logic [1:0] mode, input logic [DATA_W-1:0] exp_data);
    row_t r;
    r = '{wr, addr, data, byte_en, tm, t_ofs, sts, mode, exp_data};
    rows.push_back(r);
  endtask

  function automatic logic [ADDR_W-1:0] scratch_addr(input int idx);
    return ADDR_W'(REG_BANK_BASE + 4 * idx);
  endfunction

  // ----------------------------------------------------------
  // Test table
  // ----------------------------------------------------------

  task automatic build_table();
    logic [BYTE_EN_W-1:0] be_mix [NUM_SCRATCH];
    int                   i;
    be_mix = '{4'h3, 4'hC, 4'h5, 4'hA};
    // Every scratch register reads zero after reset
    for (i = 0; i < NUM_SCRATCH; i++) begin
      add_row(1'b0, scratch_addr(i), '0, 4'hF, TM_NONE, 0, STS_OKAY, EXP_MODEL, '0);
    end
    // Full words first, then single byte lanes over them, then read back
    for (i = 0; i < NUM_SCRATCH; i++) begin
      add_row(1'b1, scratch_addr(i), $random(seed), 4'hF, TM_NONE, 0,
              STS_OKAY, EXP_FIXED, '0);
    end
    for (i = 0; i < NUM_SCRATCH; i++) begin
      add_row(1'b1, scratch_addr(i), $random(seed), be_mix[i], TM_NONE, 0,
              STS_OKAY, EXP_FIXED, '0);
    end
    for (i = 0; i < NUM_SCRATCH; i++) begin
      add_row(1'b0, scratch_addr(i), '0, 4'hF, TM_NONE, 0, STS_OKAY, EXP_MODEL, '0);
    end
    // Nobody maps these, so the gate times out
    add_row(1'b0, 20'h00200, '0, 4'hF, TM_NONE, 0, STS_CMDERR, EXP_FIXED, '0);
    add_row(1'b1, 20'h00F00, $random(seed), 4'hF, TM_NONE, 0, STS_CMDERR, EXP_FIXED, '0);
    // Set the time high half first, the low write commits both
    add_row(1'b1, TIME_HI, T_HI, 4'hF, TM_NONE, 0, STS_OKAY, EXP_FIXED, '0);
    add_row(1'b1, TIME_LO, T_LO, 4'hF, TM_NONE, 0, STS_OKAY, EXP_FIXED, '0);
    add_row(1'b0, TIME_LO, '0, 4'hF, TM_NONE, 0, STS_OKAY, EXP_MIN, '0);
    add_row(1'b0, TIME_HI, '0, 4'hF, TM_NONE, 0, STS_OKAY, EXP_FIXED, T_HI);
    // Timed write 40 ticks past the last reading is held back, then lands
    add_row(1'b0, TIME_LO, '0, 4'hF, TM_NONE, 0, STS_OKAY, EXP_MIN, '0);
    add_row(1'b1, scratch_addr(2), $random(seed), 4'hF, TM_AHEAD, 40,
            STS_OKAY, EXP_FIXED, '0);
    add_row(1'b0, TIME_LO, '0, 4'hF, TM_NONE, 0, STS_OKAY, EXP_MIN, '0);
    add_row(1'b0, scratch_addr(2), '0, 4'hF, TM_NONE, 0, STS_OKAY, EXP_MODEL, '0);
    // A time already gone is refused and the register keeps its value
    add_row(1'b0, TIME_LO, '0, 4'hF, TM_NONE, 0, STS_OKAY, EXP_MIN, '0);
    add_row(1'b1, scratch_addr(1), $random(seed), 4'hF, TM_LATE, -8,
            STS_TSERR, EXP_FIXED, '0);
    add_row(1'b0, scratch_addr(1), '0, 4'hF, TM_NONE, 0, STS_OKAY, EXP_MODEL, '0);
  endtask

  // ----------------------------------------------------------
  // Request and response
  // ----------------------------------------------------------

  task automatic send_request(input int n);
    row_t              r;
    int                lat;
    int                idx;
    int                b;
    logic [DATA_W-1:0] req_lo;
    logic [DATA_W-1:0] exp_data;
    r      = rows[n];
    req_lo = last_lo + r.t_ofs;
    idx    = int'(r.addr[SCRATCH_IDX_W+1:2]);
    @(posedge ctrlport_clk);
    // The previous answer must have been a single-cycle pulse
    check_value("resp_ack", 64'(resp_ack), 64'(0));
    req_wr       <= r.wr;
    req_rd       <= !r.wr;
    req_addr     <= r.addr;
    req_data     <= r.data;
    req_byte_en  <= r.byte_en;
    req_has_time <= (r.tm != TM_NONE);
    req_time     <= {T_HI, req_lo};
    if (r.tm == TM_AHEAD) begin
      min_lo = req_lo;
    end
    @(posedge ctrlport_clk);
    req_wr <= 1'b0;
    req_rd <= 1'b0;
    lat    = 0;
    // Latency counts from the edge on which the gate took the request
    while (!resp_ack) begin
      @(posedge ctrlport_clk);
      lat++;
      if (lat > ACK_LIMIT) begin
        $display("Timeout: row %0d got no resp_ack within %0d cycles", n, ACK_LIMIT);
        $display("TB FAILED");
        $fatal(1, "No response from the DUT");
      end
    end

    check_value("resp_status", 64'(resp_status), 64'(r.sts));
    exp_data = (r.mode == EXP_MODEL) ? model[idx] : r.exp_data;
    if (r.mode == EXP_MIN) begin
      check_value("time_lo not below minimum", 64'(resp_data >= min_lo), 64'(1));
    end else begin
      check_value("resp_data", 64'(resp_data), 64'(exp_data));
    end
    // Gate, slave and splitter each add one cycle to an untimed hit
    if (r.tm == TM_NONE && r.sts == STS_OKAY) begin
      check_value("response latency", 64'(lat), 64'(4));
    end
    if (r.tm == TM_LATE) begin
      check_value("reject latency", 64'(lat), 64'(1));
    end
    if (!r.wr && r.addr == TIME_LO) begin
      last_lo = resp_data;
    end
    // Accepted scratch writes change only the enabled byte lanes
    if (r.wr && r.sts == STS_OKAY && r.addr < TIMEKEEPER_BASE) begin
      for (b = 0; b < BYTE_EN_W; b++) begin
        if (r.byte_en[b]) begin
          model[idx][8*b +: 8] = r.data[8*b +: 8];
        end
      end
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    int i;
    ctrlport_rst <= 1'b1;
    req_wr       <= 1'b0;
    req_rd       <= 1'b0;
    req_addr     <= '0;
    req_data     <= '0;
    req_byte_en  <= '0;
    req_has_time <= 1'b0;
    req_time     <= '0;
    last_lo = T_LO;
    min_lo  = T_LO;
    for (i = 0; i < NUM_SCRATCH; i++) begin
      model[i] = '0;
    end
    build_table();
    repeat (10) @(posedge ctrlport_clk);
    ctrlport_rst <= 1'b0;
    // No request, so no acknowledge
    for (i = 0; i < 20; i++) begin
      @(posedge ctrlport_clk);
      check_value("resp_ack", 64'(resp_ack), 64'(0));
    end
    for (i = 0; i < rows.size(); i++) begin
      send_request(i);
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/ctrlport_pkg.sv
logic/ctrlport_if.sv
logic/ctrlport_splitter.sv
logic/ctrlport_timed_gate.sv
logic/ctrlport_timekeeper.sv
logic/ctrlport_reg_bank.sv
logic/ctrlport_timed_regs.sv
testbench/tb_ctrlport_timed_regs.sv

// ==== Makefile ====
# Verilator simulation of the timed control-port register subsystem

VERILATOR ?= verilator
TOP       ?= tb_ctrlport_timed_regs
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Pass or fail is taken from the log, not from the exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
